// ==== flist.f ====
source/scc_pkg.sv
source/scc_wave_ram.sv
source/scc_oscillator.sv
source/scc_channel.sv
source/scc_mixer.sv
source/scc_reg_block.sv
source/scc_top.sv
test/scc_props.sv
test/tb_scc_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SCC testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scc_top -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_scc_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== test/tb_scc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_scc_top;

    import scc_pkg::*;

    localparam int MAX_CYCLES = 6000;
    localparam int WAVE_TOP   = NUM_CH * WAVE_BASE_STRIDE;

    logic                      emuclk;
    logic                      rst_n;
    logic                      i_wr;
    logic                      i_rd;
    logic [ADDR_W-1:0]         i_addr;
    logic [DATA_W-1:0]         i_wdata;
    wire  [DATA_W-1:0]         o_rdata;
    wire  signed [SOUND_W-1:0] o_sound;

    integer seed;
    int     cycles       = 0;
    int     sound_errors = 0;
    int     rdata_errors = 0;

    // Reference model state
    logic [DATA_W-1:0] m_ram [NUM_CH][1 << WAVE_AW];
    int                m_freq [NUM_CH];
    int                m_vol [NUM_CH];
    logic [NUM_CH-1:0] m_en;
    int                m_div [NUM_CH];
    int                m_idx [NUM_CH];
    int                m_samp [NUM_CH];
    int                exp_sound;
    logic [DATA_W-1:0] exp_rdata;

    scc_top DUT (
        .emuclk  (emuclk),
        .rst_n   (rst_n),
        .i_wr    (i_wr),
        .i_rd    (i_rd),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .o_rdata (o_rdata),
        .o_sound (o_sound)
    );

    bind scc_top scc_props u_props (
        .emuclk  (emuclk),
        .rst_n   (rst_n),
        .i_rd    (i_rd),
        .i_rdata (o_rdata),
        .i_sound (o_sound)
    );

    always #50 emuclk = ~emuclk;

    ////////////////////////////////////////
    // Cycle model
    ////////////////////////////////////////

    task automatic model_step();
        int  a;
        int  b;
        int  c;
        int  sum;
        int  nf [NUM_CH];
        bit  rl [NUM_CH];
        if (!rst_n) begin
            for (c = 0; c < NUM_CH; c++) begin
                m_freq[c] = 0;
                m_vol[c]  = 0;
                m_div[c]  = 0;
                m_idx[c]  = 0;
                m_samp[c] = 0;
            end
            m_en      = '0;
            exp_sound = 0;
            exp_rdata = '0;
            return;
        end
        a = i_addr;
        if (i_rd && a < WAVE_TOP) begin
            exp_rdata = m_ram[a / WAVE_BASE_STRIDE][a % WAVE_BASE_STRIDE];
        end else begin
            exp_rdata = '0;
        end
        // Mixer stage sees last cycle's channel samples
        sum = 0;
        for (c = 0; c < NUM_CH; c++) begin
            sum += m_samp[c];
        end
        exp_sound = sum;
        for (c = 0; c < NUM_CH; c++) begin
            b = $signed(m_ram[c][m_idx[c]]);
            m_samp[c] = m_en[c] ? (b * m_vol[c]) >>> VOL_W : 0;
            nf[c] = m_freq[c];
            rl[c] = 1'b0;
        end
        if (i_wr) begin
            if (a < WAVE_TOP) begin
                m_ram[a / WAVE_BASE_STRIDE][a % WAVE_BASE_STRIDE] = i_wdata;
            end else if (a >= FREQ_BASE && a < FREQ_BASE + 2 * NUM_CH) begin
                c = (a - FREQ_BASE) / 2;
                if ((a - FREQ_BASE) % 2 == 0) begin
                    nf[c] = (m_freq[c] & 'hF00) | i_wdata;
                end else begin
                    nf[c] = (m_freq[c] & 'h0FF) | ((i_wdata & 'hF) << 8);
                end
                rl[c] = 1'b1;
            end else if (a >= VOL_BASE && a < VOL_BASE + NUM_CH) begin
                m_vol[a - VOL_BASE] = i_wdata & 'hF;
            end else if (a == ENABLE_ADDR) begin
                m_en = i_wdata[NUM_CH-1:0];
            end
        end
        for (c = 0; c < NUM_CH; c++) begin
            if (rl[c]) begin
                m_div[c] = nf[c];
            end else if (m_div[c] == 0) begin
                m_div[c] = nf[c];
                m_idx[c] = (m_idx[c] + 1) % (1 << WAVE_AW);
            end else begin
                m_div[c]--;
            end
            m_freq[c] = nf[c];
        end
    endtask

    always @(posedge emuclk) model_step();

    // Outputs are settled at the falling edge
    always @(negedge emuclk) begin
        if (rst_n) begin
            assert ($signed(o_sound) === exp_sound) else begin
                sound_errors++;
                $display("** Error: time %0t, o_sound expected %0d, actual %0d",
                         $time, exp_sound, $signed(o_sound));
            end
            assert (o_rdata === exp_rdata) else begin
                rdata_errors++;
                $display("** Error: time %0t, o_rdata expected 0x%02h, actual 0x%02h",
                         $time, exp_rdata, o_rdata);
            end
        end
    end

    ////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic bus_write(input int addr, input int data);
        @(posedge emuclk);
        i_wr    <= 1'b1;
        i_rd    <= 1'b0;
        i_addr  <= addr[ADDR_W-1:0];
        i_wdata <= data[DATA_W-1:0];
    endtask

    task automatic bus_read(input int addr);
        @(posedge emuclk);
        i_wr   <= 1'b0;
        i_rd   <= 1'b1;
        i_addr <= addr[ADDR_W-1:0];
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            @(posedge emuclk);
            i_wr <= 1'b0;
            i_rd <= 1'b0;
        end
    endtask

    task automatic set_channel(input int c, input int freq, input int vol);
        bus_write(FREQ_BASE + 2 * c, freq & 'hFF);
        bus_write(FREQ_BASE + 2 * c + 1, freq >> 8);
        bus_write(VOL_BASE + c, vol);
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            bus_idle(1);
            @(negedge emuclk);
            assert (o_sound === '0) else begin
                sound_errors++;
                $display("** Error: time %0t, o_sound expected 0, actual %0d",
                         $time, $signed(o_sound));
            end
            assert (o_rdata === '0) else begin
                rdata_errors++;
                $display("** Error: time %0t, o_rdata expected 0x00, actual 0x%02h",
                         $time, o_rdata);
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        int a;
        int c;
        emuclk  = 1'b0;
        rst_n   = 1'b0;
        i_wr    = 1'b0;
        i_rd    = 1'b0;
        i_addr  = '0;
        i_wdata = '0;
        seed    = 53;
        repeat (3) @(posedge emuclk);
        rst_n <= 1'b1;
        check_quiet(2);

        // Silent while every channel is disabled
        for (a = 0; a < WAVE_TOP; a++) begin
            bus_write(a, rand_below(256));
        end
        for (c = 0; c < NUM_CH; c++) begin
            set_channel(c, rand_below(4096), rand_below(16));
        end
        check_quiet(60);

        // Wave RAM readback and unmapped reads
        for (a = 0; a < WAVE_TOP; a++) begin
            bus_write(a, rand_below(256));
        end
        for (a = 0; a < WAVE_TOP; a++) begin
            bus_read(a);
        end
        repeat (24) bus_read(WAVE_TOP + rand_below(256 - WAVE_TOP));
        bus_idle(2);

        // One voice at full volume
        for (c = 0; c < NUM_CH; c++) begin
            set_channel(c, rand_below(8), 15);
            bus_write(ENABLE_ADDR, 1 << c);
            bus_idle(250);
        end

        // All voices with random settings
        repeat (6) begin
            for (c = 0; c < NUM_CH; c++) begin
                set_channel(c, rand_below(64), rand_below(16));
            end
            bus_write(ENABLE_ADDR, rand_below(8));
            bus_idle(300);
        end

        // Frequency rewrites while playing
        bus_write(ENABLE_ADDR, 7);
        repeat (6) begin
            bus_idle(60 + rand_below(40));
            c = rand_below(NUM_CH);
            bus_write(FREQ_BASE + 2 * c, rand_below(32));
            bus_idle(rand_below(5));
            bus_write(FREQ_BASE + 2 * c + 1, 0);
        end
        bus_idle(100);

        // Enable bits toggled one at a time
        for (c = 0; c < NUM_CH; c++) begin
            bus_write(ENABLE_ADDR, 7 & ~(1 << c));
            bus_idle(40);
            bus_write(ENABLE_ADDR, 7);
            bus_idle(40);
        end
        bus_write(ENABLE_ADDR, 0);
        bus_idle(3);
        @(negedge emuclk);
        assert (o_sound === '0) else begin
            sound_errors++;
            $display("** Error: time %0t, o_sound expected 0, actual %0d",
                     $time, $signed(o_sound));
        end
        bus_idle(4);

        $display("Errors: o_sound %0d, o_rdata %0d", sound_errors, rdata_errors);
        if (sound_errors + rdata_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run limit
    always @(posedge emuclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: o_sound %0d, o_rdata %0d", sound_errors, rdata_errors);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/scc_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module scc_props (
    input wire                                emuclk,
    input wire                                rst_n,
    input wire                                i_rd,
    input wire        [scc_pkg::DATA_W-1:0]   i_rdata,
    input wire signed [scc_pkg::SOUND_W-1:0]  i_sound
);

    ////////////////////////////////////////
    // Bus and output properties
    ////////////////////////////////////////

    // Read data register clears when no read is issued
    rdata_cleared: assert property (
        @(posedge emuclk) disable iff (!rst_n)
        !i_rd |=> i_rdata == '0
    ) else $error("o_rdata held a value after a cycle without a read");

    // Pipeline starts from silence
    sound_after_reset: assert property (
        @(posedge emuclk)
        $rose(rst_n) |=> i_sound == '0
    ) else $error("o_sound not zero two cycles after reset release");

    sound_known: assert property (
        @(posedge emuclk) disable iff (!rst_n)
        !$isunknown(i_sound)
    ) else $error("o_sound has unknown bits");

endmodule

`default_nettype wire

// ==== source/scc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module scc_top (
    input  wire                                 emuclk,
    input  wire                                 rst_n,
    input  wire                                 i_wr,
    input  wire                                 i_rd,
    input  wire         [scc_pkg::ADDR_W-1:0]   i_addr,
    input  wire         [scc_pkg::DATA_W-1:0]   i_wdata,
    output logic        [scc_pkg::DATA_W-1:0]   o_rdata,
    output logic signed [scc_pkg::SOUND_W-1:0]  o_sound
);

    import scc_pkg::*;

    logic [NUM_CH*DATA_W-1:0] wave_rdata;
    logic [NUM_CH-1:0]        wave_we;
    logic [NUM_CH*FREQ_W-1:0] freq;
    logic [NUM_CH-1:0]        freq_reload;
    logic [NUM_CH*VOL_W-1:0]  vol;
    logic [NUM_CH-1:0]        ch_enable;
    logic [NUM_CH*DATA_W-1:0] samples;

    ////////////////////////////////////////
    // Register block
    ////////////////////////////////////////

    scc_reg_block u_reg_block (
        .emuclk        (emuclk),
        .rst_n         (rst_n),
        .i_wr          (i_wr),
        .i_rd          (i_rd),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .i_wave_rdata  (wave_rdata),
        .o_rdata       (o_rdata),
        .o_wave_we     (wave_we),
        .o_freq        (freq),
        .o_freq_reload (freq_reload),
        .o_vol         (vol),
        .o_ch_enable   (ch_enable)
    );

    ////////////////////////////////////////
    // Voices
    ////////////////////////////////////////

    // All channels see the same in-window byte address
    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        scc_channel u_channel (
            .emuclk    (emuclk),
            .rst_n     (rst_n),
            .i_we      (wave_we[c]),
            .i_addr_lo (i_addr[WAVE_AW-1:0]),
            .i_wdata   (i_wdata),
            .i_freq    (freq[c*FREQ_W +: FREQ_W]),
            .i_reload  (freq_reload[c]),
            .i_vol     (vol[c*VOL_W +: VOL_W]),
            .i_enable  (ch_enable[c]),
            .o_cpu_q   (wave_rdata[c*DATA_W +: DATA_W]),
            .o_sample  (samples[c*DATA_W +: DATA_W])
        );
    end

    ////////////////////////////////////////
    // Output mix
    ////////////////////////////////////////

    scc_mixer u_mixer (
        .emuclk    (emuclk),
        .rst_n     (rst_n),
        .i_samples (samples),
        .o_sound   (o_sound)
    );

endmodule

`default_nettype wire

// ==== source/scc_reg_block.sv ====
`timescale 1ns/100ps
`default_nettype none

module scc_reg_block (
    input  wire                                          emuclk,
    input  wire                                          rst_n,
    input  wire                                          i_wr,
    input  wire                                          i_rd,
    input  wire  [scc_pkg::ADDR_W-1:0]                   i_addr,
    input  wire  [scc_pkg::DATA_W-1:0]                   i_wdata,
    input  wire  [scc_pkg::NUM_CH*scc_pkg::DATA_W-1:0]   i_wave_rdata,
    output logic [scc_pkg::DATA_W-1:0]                   o_rdata,
    output logic [scc_pkg::NUM_CH-1:0]                   o_wave_we,
    output logic [scc_pkg::NUM_CH*scc_pkg::FREQ_W-1:0]   o_freq,
    output logic [scc_pkg::NUM_CH-1:0]                   o_freq_reload,
    output logic [scc_pkg::NUM_CH*scc_pkg::VOL_W-1:0]    o_vol,
    output logic [scc_pkg::NUM_CH-1:0]                   o_ch_enable
);

    import scc_pkg::*;

    bus_target_e                         target;
    logic [CH_W-1:0]                     ch_sel;
    logic [ADDR_W-1:0]                   freq_off;
    logic [ADDR_W-1:0]                   vol_off;
    logic [NUM_CH-1:0][DATA_W-1:0]       wave_rd;
    logic [NUM_CH-1:0][FREQ_W-1:0]       freq_q;
    logic [NUM_CH-1:0][FREQ_W-1:0]       freq_next;
    logic [NUM_CH-1:0][VOL_W-1:0]        vol_q;
    logic [NUM_CH-1:0]                   en_q;
    logic [DATA_W-1:0]                   rdata_q;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    // Offsets wrap below their base, so one compare bounds each range
    assign freq_off = i_addr - FREQ_BASE;
    assign vol_off  = i_addr - VOL_BASE;

    always_comb begin
        target = BT_NONE;
        ch_sel = '0;
        if (i_addr < NUM_CH * WAVE_BASE_STRIDE) begin
            target = BT_WAVE;
            ch_sel = i_addr[WAVE_AW +: CH_W];
        end else if (freq_off < 2 * NUM_CH) begin
            target = freq_off[0] ? BT_FREQ_HI : BT_FREQ_LO;
            ch_sel = freq_off[CH_W:1];
        end else if (vol_off < NUM_CH) begin
            target = BT_VOL;
            ch_sel = vol_off[CH_W-1:0];
        end else if (i_addr == ENABLE_ADDR) begin
            target = BT_ENABLE;
        end
    end

    ////////////////////////////////////////
    // Strobes and merged frequency
    ////////////////////////////////////////

    always_comb begin
        freq_next     = freq_q;
        o_wave_we     = '0;
        o_freq_reload = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (i_wr && ch_sel == c) begin
                o_wave_we[c]     = (target == BT_WAVE);
                o_freq_reload[c] = (target == BT_FREQ_LO) || (target == BT_FREQ_HI);
                if (target == BT_FREQ_LO) begin
                    freq_next[c][DATA_W-1:0] = i_wdata;
                end
                if (target == BT_FREQ_HI) begin
                    freq_next[c][FREQ_W-1:DATA_W] = i_wdata[FREQ_W-DATA_W-1:0];
                end
            end
        end
    end

    // Oscillators see the written value in the reload cycle itself
    assign o_freq = freq_next;

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    assign wave_rd = i_wave_rdata;

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            freq_q  <= '0;
            vol_q   <= '0;
            en_q    <= '0;
            rdata_q <= '0;
        end else begin
            freq_q <= freq_next;
            for (int c = 0; c < NUM_CH; c++) begin
                if (i_wr && target == BT_VOL && ch_sel == c) begin
                    vol_q[c] <= i_wdata[VOL_W-1:0];
                end
            end
            if (i_wr && target == BT_ENABLE) begin
                en_q <= i_wdata[NUM_CH-1:0];
            end
            // Only wave RAM is readable, everything else returns zero
            if (i_rd && target == BT_WAVE) begin
                rdata_q <= wave_rd[ch_sel];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign o_vol       = vol_q;
    assign o_ch_enable = en_q;
    assign o_rdata     = rdata_q;

endmodule

`default_nettype wire

// ==== source/scc_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module scc_mixer (
    input  wire                                          emuclk,
    input  wire                                          rst_n,
    input  wire  [scc_pkg::NUM_CH*scc_pkg::DATA_W-1:0]   i_samples,
    output logic signed [scc_pkg::SOUND_W-1:0]           o_sound
);

    import scc_pkg::*;

    logic [NUM_CH-1:0][DATA_W-1:0] samples;
    logic signed [SOUND_W-1:0]     sum;

    assign samples = i_samples;

    always_comb begin
        sum = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            sum = sum + $signed({{(SOUND_W-DATA_W){samples[c][DATA_W-1]}}, samples[c]});
        end
    end

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            o_sound <= '0;
        end else begin
            o_sound <= sum;
        end
    end

endmodule

`default_nettype wire

// ==== source/scc_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module scc_channel (
    input  wire                                 emuclk,
    input  wire                                 rst_n,
    input  wire                                 i_we,
    input  wire         [scc_pkg::WAVE_AW-1:0]  i_addr_lo,
    input  wire         [scc_pkg::DATA_W-1:0]   i_wdata,
    input  wire         [scc_pkg::FREQ_W-1:0]   i_freq,
    input  wire                                 i_reload,
    input  wire         [scc_pkg::VOL_W-1:0]    i_vol,
    input  wire                                 i_enable,
    output logic        [scc_pkg::DATA_W-1:0]   o_cpu_q,
    output logic signed [scc_pkg::DATA_W-1:0]   o_sample
);

    import scc_pkg::*;

    logic        [WAVE_AW-1:0]      index;
    logic        [DATA_W-1:0]       play_q;
    logic signed [DATA_W+VOL_W:0]   prod;

    scc_wave_ram u_wave_ram (
        .emuclk      (emuclk),
        .i_we        (i_we),
        .i_waddr     (i_addr_lo),
        .i_wdata     (i_wdata),
        .i_cpu_addr  (i_addr_lo),
        .i_play_addr (index),
        .o_cpu_q     (o_cpu_q),
        .o_play_q    (play_q)
    );

    scc_oscillator u_oscillator (
        .emuclk   (emuclk),
        .rst_n    (rst_n),
        .i_freq   (i_freq),
        .i_reload (i_reload),
        .o_index  (index)
    );

    ////////////////////////////////////////
    // Volume scaling
    ////////////////////////////////////////

    // Volume is unsigned, so it gets a zero sign bit
    assign prod = $signed(play_q) * $signed({1'b0, i_vol});

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            o_sample <= '0;
        end else if (i_enable) begin
            // Same as prod >>> VOL_W truncated to a byte
            o_sample <= prod[DATA_W+VOL_W-1:VOL_W];
        end else begin
            o_sample <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/scc_oscillator.sv ====
`timescale 1ns/100ps
`default_nettype none

module scc_oscillator (
    input  wire                          emuclk,
    input  wire                          rst_n,
    input  wire  [scc_pkg::FREQ_W-1:0]   i_freq,
    input  wire                          i_reload,
    output logic [scc_pkg::WAVE_AW-1:0]  o_index
);

    import scc_pkg::*;

    logic [FREQ_W-1:0]  div_q;
    logic [WAVE_AW-1:0] idx_q;
    logic               div_zero;

    assign div_zero = (div_q == '0);

    ////////////////////////////////////////
    // Divider and wave index
    ////////////////////////////////////////

    // Index steps once every i_freq+1 cycles
    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
            idx_q <= '0;
        end else if (i_reload) begin
            // Restart the period, phase is kept
            div_q <= i_freq;
        end else if (div_zero) begin
            div_q <= i_freq;
            idx_q <= idx_q + 1'b1;
        end else begin
            div_q <= div_q - 1'b1;
        end
    end

    assign o_index = idx_q;

endmodule

`default_nettype wire

// ==== source/scc_wave_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module scc_wave_ram (
    input  wire                          emuclk,
    input  wire                          i_we,
    input  wire  [scc_pkg::WAVE_AW-1:0]  i_waddr,
    input  wire  [scc_pkg::DATA_W-1:0]   i_wdata,
    input  wire  [scc_pkg::WAVE_AW-1:0]  i_cpu_addr,
    input  wire  [scc_pkg::WAVE_AW-1:0]  i_play_addr,
    output logic [scc_pkg::DATA_W-1:0]   o_cpu_q,
    output logic [scc_pkg::DATA_W-1:0]   o_play_q
);

    import scc_pkg::*;

    logic [DATA_W-1:0] mem [0:(1 << WAVE_AW)-1];

    always_ff @(posedge emuclk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Two asynchronous read ports
    assign o_cpu_q  = mem[i_cpu_addr];
    assign o_play_q = mem[i_play_addr];

endmodule

`default_nettype wire

// ==== source/scc_pkg.sv ====
`default_nettype none

package scc_pkg;

    ////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////

    localparam int NUM_CH  = 3;
    localparam int CH_W    = $clog2(NUM_CH);
    localparam int ADDR_W  = 8;
    localparam int DATA_W  = 8;
    localparam int WAVE_AW = 5;
    localparam int FREQ_W  = 12;
    localparam int VOL_W   = 4;
    localparam int SOUND_W = 11;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////

    // Each channel owns one 32-byte window of wave RAM
    localparam int WAVE_BASE_STRIDE = 'h20;

    // Low byte at even offsets, high nibble at odd offsets
    localparam logic [ADDR_W-1:0] FREQ_BASE = 8'h80;

    localparam logic [ADDR_W-1:0] VOL_BASE = 8'h8A;

    // One enable bit per channel
    localparam logic [ADDR_W-1:0] ENABLE_ADDR = 8'h8F;

    // Targets of a bus access
    typedef enum logic [2:0] {
        BT_WAVE,
        BT_FREQ_LO,
        BT_FREQ_HI,
        BT_VOL,
        BT_ENABLE,
        BT_NONE
    } bus_target_e;

endpackage

`default_nettype wire
